//--- common/core_pkg.sv
package core_pkg;

    typedef logic [7:0]  data_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] word_t;
    typedef logic [2:0]  m_cycle_t;  // Step within an instruction

    // Four T-states per machine cycle
    typedef enum logic [1:0] {PH_ADDR, PH_WAIT, PH_DATA, PH_IDLE} phase_t;

    typedef enum logic [1:0] {BUS_NONE, BUS_FETCH, BUS_WRITE, BUS_READ} bus_op_t;

    typedef enum logic [1:0] {AB_PC, AB_IMM, AB_HL} ab_src_t;

    typedef enum logic [1:0] {A_ACC, A_PC_LO, A_PC_HI} a_src_t;

    typedef enum logic [2:0] {B_REG, B_IMM, B_ABS_IMM, B_ONE, B_ZERO} b_src_t;

    typedef enum logic [2:0] {DST_NONE, DST_A, DST_PC, DST_RF, DST_IMM} dst_t;

    localparam addr_t reset_pc = 16'h0000;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    // Register codes as they sit in the opcode fields
    typedef logic [2:0] reg_sel_t;

    localparam reg_sel_t reg_h      = 3'd4;
    localparam reg_sel_t reg_l      = 3'd5;
    localparam reg_sel_t reg_hl_mem = 3'd6;  // Also the immediate slot in 00rrr110 / 11ooo110
    localparam reg_sel_t reg_a      = 3'd7;
    localparam int       num_gp_regs = 6;    // B C D E H L

    // Accumulator operations follow opcode bits [5:3]
    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR, ALU_CP,
        ALU_PASS,
        ALU_ADDC_PC
    } alu_op_t;

    typedef logic [3:0] flags_t;

    localparam int flag_z = 3;
    localparam int flag_n = 2;
    localparam int flag_h = 1;
    localparam int flag_c = 0;

    localparam logic [7:0] op_nop     = 8'h00;
    localparam logic [7:0] op_halt    = 8'h76;
    localparam logic [7:0] op_jp      = 8'hc3;
    localparam logic [7:0] op_jr      = 8'h18;
    localparam logic [7:0] op_ld_hl_a = 8'h77;
    localparam logic [7:0] op_ld_a_hl = 8'h7e;

    // Opcode groups from bits [7:6]
    localparam logic [1:0] grp_ld_rn = 2'b00;
    localparam logic [1:0] grp_ld_rr = 2'b01;
    localparam logic [1:0] grp_alu_r = 2'b10;
    localparam logic [1:0] grp_alu_n = 2'b11;

endpackage

//--- datapath/alu.sv
module alu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_t op,
    input  logic    carry_in,
    input  flags_t  flags_in,
    output data_t   result,
    output flags_t  flags_out
);

    logic       cin;
    logic [8:0] sum;
    logic [8:0] diff;
    logic [4:0] half_sum;
    logic [4:0] half_diff;

    assign cin       = (op == ALU_ADC || op == ALU_SBC || op == ALU_ADDC_PC) ? carry_in : 1'b0;
    assign sum       = {1'b0, a} + {1'b0, b} + {8'd0, cin};
    assign diff      = {1'b0, a} - {1'b0, b} - {8'd0, cin};
    assign half_sum  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
    assign half_diff = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'd0, cin};  // Bit 4 is half borrow

    always_comb begin
        result    = b;
        flags_out = flags_in;
        case (op)
            ALU_ADD, ALU_ADC: begin
                result    = sum[7:0];
                flags_out = {sum[7:0] == 8'd0, 1'b0, half_sum[4], sum[8]};
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                result    = (op == ALU_CP) ? a : diff[7:0];  // CP only compares
                flags_out = {diff[7:0] == 8'd0, 1'b1, half_diff[4], diff[8]};
            end
            ALU_AND: begin
                result    = a & b;
                flags_out = {(a & b) == 8'd0, 1'b0, 1'b1, 1'b0};
            end
            ALU_XOR: begin
                result    = a ^ b;
                flags_out = {(a ^ b) == 8'd0, 3'b000};
            end
            ALU_OR: begin
                result    = a | b;
                flags_out = {(a | b) == 8'd0, 3'b000};
            end
            ALU_ADDC_PC: begin
                result            = sum[7:0];
                flags_out[flag_c] = sum[8];  // Carry for the next PC byte only
            end
            default: result = b;
        endcase
    end

endmodule

//--- datapath/regfile.sv
module regfile
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_sel_t rd_sel,
    output data_t    rd_data,
    input  reg_sel_t wr_sel,
    input  data_t    wr_data,
    input  logic     we,
    output word_t    hl
);

    data_t regs [num_gp_regs];  // B C D E H L

    // Codes 6 and 7 read as zero here
    assign rd_data = (rd_sel < reg_hl_mem) ? regs[rd_sel] : '0;
    assign hl      = {regs[reg_h], regs[reg_l]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_gp_regs; i++)
                regs[i] <= '0;
        end else if (we && wr_sel < reg_hl_mem) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

//--- datapath/datapath.sv
module datapath
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  a_src_t   a_src,
    input  b_src_t   b_src,
    input  alu_op_t  alu_op,
    input  dst_t     dst,
    input  reg_sel_t rf_rd_sel,
    input  reg_sel_t rf_wr_sel,
    input  bus_op_t  bus_op,
    input  ab_src_t  ab_src,
    input  logic     pc_load,
    input  phase_t   phase,
    input  m_cycle_t m_cycle,
    input  data_t    din,
    output data_t    opcode,
    output logic     imm_sign,
    output addr_t    a,
    output data_t    dout,
    output logic     rd,
    output logic     wr,
    output logic     phi
);

    addr_t  pc;
    data_t  acc;
    flags_t f;
    word_t  imm;
    logic   pc_carry;  // Carry from PC low byte into high byte
    data_t  rf_rd_data;
    word_t  hl;
    data_t  reg_operand;
    data_t  imm_abs;
    data_t  alu_a;
    data_t  alu_b;
    logic   alu_cin;
    data_t  alu_result;
    flags_t alu_flags;
    addr_t  ab_wr;

    regfile rf_inst (
        .clk     (clk),
        .rst     (rst),
        .rd_sel  (rf_rd_sel),
        .rd_data (rf_rd_data),
        .wr_sel  (rf_wr_sel),
        .wr_data (alu_result),
        .we      (dst == DST_RF),
        .hl      (hl)
    );

    alu alu_inst (
        .a         (alu_a),
        .b         (alu_b),
        .op        (alu_op),
        .carry_in  (alu_cin),
        .flags_in  (f),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    assign imm_sign = imm[7];
    assign imm_abs  = imm[7] ? ~imm[7:0] + 8'd1 : imm[7:0];  // Magnitude of JR offset

    ////////////////////////////////////////////////////////////////////////////
    // Operand and address muxes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (rf_rd_sel)
            reg_a:      reg_operand = acc;
            reg_hl_mem: reg_operand = imm[7:0];  // Byte fetched from (HL)
            default:    reg_operand = rf_rd_data;
        endcase
        case (a_src)
            A_PC_LO: alu_a = pc[7:0];
            A_PC_HI: alu_a = pc[15:8];
            default: alu_a = acc;
        endcase
        case (b_src)
            B_REG:     alu_b = reg_operand;
            B_IMM:     alu_b = imm[7:0];
            B_ABS_IMM: alu_b = imm_abs;
            B_ONE:     alu_b = 8'd1;
            default:   alu_b = 8'd0;
        endcase
        case (a_src)
            A_PC_LO: alu_cin = 1'b0;
            A_PC_HI: alu_cin = pc_carry;
            default: alu_cin = f[flag_c];
        endcase
        case (ab_src)
            AB_IMM:  ab_wr = imm;
            AB_HL:   ab_wr = hl;
            default: ab_wr = pc;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Architectural registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc     <= reset_pc;
            acc    <= '0;
            f      <= '0;
            opcode <= op_nop;
        end else begin
            if (pc_load) begin
                pc <= imm;
            end else if (dst == DST_PC) begin
                if (a_src == A_PC_HI)
                    pc[15:8] <= alu_result;
                else
                    pc[7:0] <= alu_result;
            end
            if (dst == DST_A) begin
                acc <= alu_result;
                f   <= alu_flags;
            end else if (dst == DST_RF && rf_wr_sel == reg_a) begin
                acc <= alu_result;  // Loads into A leave F alone
            end
            if (phase == PH_DATA && bus_op == BUS_FETCH)
                opcode <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (dst == DST_IMM) begin
            imm[7:0] <= alu_result;
        end else if (phase == PH_DATA && bus_op == BUS_READ) begin
            if (m_cycle == 3'd0)
                imm[7:0] <= din;
            else
                imm[15:8] <= din;
        end
        if (dst == DST_PC && a_src == A_PC_LO)
            pc_carry <= alu_flags[flag_c];
    end

    // Bus outputs, one update per phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a    <= '0;
            rd   <= 1'b0;
            wr   <= 1'b0;
            phi  <= 1'b1;
            dout <= '0;
        end else if (phase == PH_ADDR) begin
            a  <= ab_wr;
            rd <= (bus_op == BUS_FETCH || bus_op == BUS_READ);
        end else if (phase == PH_DATA) begin
            rd  <= 1'b0;
            phi <= 1'b0;
            if (bus_op == BUS_WRITE) begin
                wr   <= 1'b1;
                dout <= imm[7:0];
            end
        end else if (phase == PH_IDLE) begin
            wr   <= 1'b0;
            dout <= '0;
            phi  <= 1'b1;
        end
    end

endmodule

//--- control/control.sv
module control
    import core_pkg::*;
    import isa_pkg::*;
(
    input  data_t    opcode,
    input  logic     imm_sign,
    input  phase_t   phase,
    input  m_cycle_t m_cycle,
    output a_src_t   a_src,
    output b_src_t   b_src,
    output alu_op_t  alu_op,
    output dst_t     dst,
    output reg_sel_t rf_rd_sel,
    output reg_sel_t rf_wr_sel,
    output bus_op_t  bus_op,
    output ab_src_t  ab_src,
    output logic     pc_load,
    output logic     next,
    output logic     halt
);

    b_src_t  d_b_src;
    alu_op_t d_op;
    dst_t    d_dst;
    logic    d_pc_load;
    logic    rel_step;  // JR offset is added to PC in this step
    logic    pc_step;
    alu_op_t field_op;

    assign field_op = alu_op_t'({1'b0, opcode[5:3]});

    ////////////////////////////////////////////////////////////////////////////
    // Instruction decode, one selector set per step
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        d_b_src   = B_REG;
        d_op      = ALU_PASS;
        d_dst     = DST_NONE;
        d_pc_load = 1'b0;
        rel_step  = 1'b0;
        rf_rd_sel = opcode[2:0];
        rf_wr_sel = opcode[5:3];
        bus_op    = BUS_FETCH;   // Last step of most instructions fetches
        ab_src    = AB_PC;
        next      = 1'b0;
        halt      = 1'b0;
        if (opcode == op_nop) begin
            bus_op = BUS_FETCH;
        end else if (opcode == op_halt) begin
            bus_op = BUS_NONE;
            halt   = 1'b1;
        end else if (opcode == op_ld_a_hl) begin
            if (m_cycle == 3'd0) begin
                bus_op = BUS_READ;
                ab_src = AB_HL;
                next   = 1'b1;
            end else begin
                rf_rd_sel = reg_hl_mem;  // Byte read from (HL)
                rf_wr_sel = reg_a;
                d_dst     = DST_RF;
            end
        end else if (opcode == op_ld_hl_a) begin
            if (m_cycle == 3'd0) begin
                rf_rd_sel = reg_a;
                d_dst     = DST_IMM;     // A into the write buffer
                bus_op    = BUS_WRITE;
                ab_src    = AB_HL;
                next      = 1'b1;
            end
        end else if (opcode == op_jp) begin
            if (m_cycle < 3'd2) begin
                bus_op = BUS_READ;
                next   = 1'b1;
            end else if (m_cycle == 3'd2) begin
                bus_op    = BUS_NONE;
                d_pc_load = 1'b1;
                next      = 1'b1;
            end
        end else if (opcode == op_jr) begin
            if (m_cycle == 3'd0) begin
                bus_op = BUS_READ;
                next   = 1'b1;
            end else if (m_cycle == 3'd1) begin
                bus_op   = BUS_NONE;
                rel_step = 1'b1;
                next     = 1'b1;
            end
        end else if (opcode[7:6] == grp_ld_rr) begin
            d_dst = DST_RF;
        end else if (opcode[7:6] == grp_alu_r) begin
            d_op  = field_op;
            d_dst = DST_A;
        end else if (opcode[2:0] == reg_hl_mem &&
                     (opcode[7:6] == grp_ld_rn || opcode[7:6] == grp_alu_n)) begin
            if (m_cycle == 3'd0) begin
                bus_op = BUS_READ;       // Operand byte
                next   = 1'b1;
            end else begin
                d_b_src = B_IMM;
                d_op    = (opcode[7:6] == grp_alu_n) ? field_op : ALU_PASS;
                d_dst   = (opcode[7:6] == grp_alu_n) ? DST_A : DST_RF;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Phase gating and PC stepping
    ////////////////////////////////////////////////////////////////////////////
    assign pc_step = (bus_op == BUS_FETCH || bus_op == BUS_READ) && ab_src == AB_PC;

    always_comb begin
        a_src   = A_ACC;
        b_src   = B_ZERO;
        alu_op  = ALU_PASS;
        dst     = DST_NONE;
        pc_load = 1'b0;
        case (phase)
            PH_ADDR: begin
                b_src   = d_b_src;
                alu_op  = d_op;
                dst     = d_dst;
                pc_load = d_pc_load;
            end
            PH_WAIT: begin
                if (rel_step) begin
                    a_src  = A_PC_LO;
                    b_src  = B_ABS_IMM;
                    alu_op = imm_sign ? ALU_SUB : ALU_ADDC_PC;
                    dst    = DST_PC;
                end else if (pc_step) begin
                    a_src  = A_PC_LO;
                    b_src  = B_ONE;
                    alu_op = ALU_ADDC_PC;
                    dst    = DST_PC;
                end
            end
            PH_DATA: begin
                if (rel_step || pc_step) begin
                    a_src  = A_PC_HI;     // High byte takes the saved carry
                    alu_op = (rel_step && imm_sign) ? ALU_SBC : ALU_ADDC_PC;
                    dst    = DST_PC;
                end
            end
            default: dst = DST_NONE;
        endcase
    end

endmodule

//--- control/cycle_sequencer.sv
module cycle_sequencer
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     next,
    input  logic     halt,
    output phase_t   phase,
    output m_cycle_t m_cycle,
    output logic     done
);

    logic halted;
    logic step_next;  // Taken before a fetch replaces the opcode
    logic step_halt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= PH_ADDR;
            m_cycle   <= '0;
            halted    <= 1'b0;
            done      <= 1'b0;
            step_next <= 1'b0;
            step_halt <= 1'b0;
        end else begin
            done <= halted;  // One clock behind the latch
            case (phase)
                PH_ADDR: phase <= PH_WAIT;
                PH_WAIT: phase <= PH_DATA;
                PH_DATA: begin
                    phase     <= PH_IDLE;
                    step_next <= next;
                    step_halt <= halt;
                end
                default: begin
                    if (halted || step_halt) begin
                        halted <= 1'b1;  // Parked in idle for good
                    end else begin
                        phase   <= PH_ADDR;
                        m_cycle <= step_next ? m_cycle + 3'd1 : 3'd0;
                    end
                end
            endcase
        end
    end

endmodule

//--- rtl/cpu.sv
module cpu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  data_t din,
    output addr_t a,
    output data_t dout,
    output logic  rd,
    output logic  wr,
    output logic  phi,
    output logic  done
);

    phase_t   phase;
    m_cycle_t m_cycle;
    data_t    opcode;
    logic     imm_sign;
    logic     next;
    logic     halt;
    logic     pc_load;

    a_src_t   a_src;
    b_src_t   b_src;
    alu_op_t  alu_op;
    dst_t     dst;
    reg_sel_t rf_rd_sel;
    reg_sel_t rf_wr_sel;
    bus_op_t  bus_op;
    ab_src_t  ab_src;

    cycle_sequencer seq_inst (.*);

    control ctrl_inst (.*);

    datapath dp_inst (.*);

endmodule

//--- bench/cpu_tb.sv
module cpu_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic  clk = 1'b0;
    logic  rst;
    data_t din;
    addr_t a;
    data_t dout;
    logic  rd;
    logic  wr;
    logic  phi;
    logic  done;

    data_t mem [0:65535];
    string exp_name [$];
    addr_t exp_addr [$];
    data_t exp_data [$];
    int    write_idx = 0;
    int    mem_lines = 0;
    bit    loaded = 1'b0;

    cpu cpu_inst (
        .clk  (clk),
        .rst  (rst),
        .din  (din),
        .a    (a),
        .dout (dout),
        .rd   (rd),
        .wr   (wr),
        .phi  (phi),
        .done (done)
    );

    always #4 clk = ~clk;  // 8 ns period

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////////////////////
    task automatic stop_failed(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual)
            stop_failed($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
    endtask

    // Compare one bus write against the next entry of the expected list
    task automatic record_write(input addr_t addr, input data_t data);
        if (write_idx >= exp_name.size()) begin
            stop_failed($sformatf("unexpected write of %h to address %h after the last expected one",
                                  data, addr));
        end else begin
            check_value({exp_name[write_idx], " address"}, exp_addr[write_idx], addr);
            check_value({exp_name[write_idx], " data"}, {8'd0, exp_data[write_idx]},
                        {8'd0, data});
            write_idx++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Memory image and expected writes
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_stimulus();
        int    fd;
        int    n;
        int    i;
        string line;
        string tag;
        string name;
        addr_t addr;
        data_t data;
        for (i = 0; i < 65536; i++)
            mem[i] = i[15:8] ^ i[7:0] ^ 8'ha5;  // Background that is never executed
        fd = $fopen("bench/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            stop_failed("cannot open bench/cpu_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#" && $sscanf(line, "%s", tag) == 1) begin
                    if (tag == "m" && $sscanf(line, "%s %h %h", tag, addr, data) == 3) begin
                        mem[addr] = data;
                        mem_lines++;
                    end else if (tag == "w" &&
                                 $sscanf(line, "%s %s %h %h", tag, name, addr, data) == 4) begin
                        exp_name.push_back(name);
                        exp_addr.push_back(addr);
                        exp_data.push_back(data);
                    end else begin
                        stop_failed({"bad line in stimulus file ", line});
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Memory model answers reads and records writes
    initial begin
        din <= '0;
        load_stimulus();
        loaded = 1'b1;
        forever begin
            @(posedge clk);
            if (rd) begin
                check_value("phi_in_read", 16'd1, {15'd0, phi});  // phi high until data edge
                din <= mem[a];
            end
            if (wr) begin
                check_value("phi_in_write", 16'd0, {15'd0, phi});
                check_value("rd_in_write", 16'd0, {15'd0, rd});
                mem[a] = dout;
                record_write(a, dout);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset, halt and final count
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (done !== 1'b1)
            @(posedge clk);
        // Core must stay parked with no more bus writes
        repeat (16) begin
            @(posedge clk);
            check_value("done_held", 16'd1, {15'd0, done});
        end
        if (write_idx == exp_name.size()) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            check_value("write_count", 16'(exp_name.size()), 16'(write_idx));
        end
    end

    // Watchdog sized from the program length
    initial begin
        int limit;
        wait (loaded);
        limit = mem_lines * 16 * 4;
        repeat (limit) @(posedge clk);
        stop_failed($sformatf("timeout, the CPU never halted within %0d clocks", limit));
    end

endmodule

//--- bench/cpu_stimulus.txt
# m address byte         memory image, hex
# w name address byte    expected bus writes in order, hex
m 0000 26
m 0001 80
m 0002 0e
m 0003 10
m 0004 69
m 0005 3e
m 0006 5a
m 0007 77
m 0008 06
m 0009 c3
m 000a 78
m 000b 77
m 000c 80
m 000d 77
m 000e ce
m 000f 4d
m 0010 77
m 0011 d6
m 0012 e0
m 0013 77
m 0014 98
m 0015 77
m 0016 90
m 0017 77
m 0018 de
m 0019 05
m 001a 77
m 001b e6
m 001c 0f
m 001d 77
m 001e b0
m 001f 77
m 0020 ee
m 0021 ff
m 0022 77
m 0023 fe
m 0024 40
m 0025 ce
m 0026 00
m 0027 77
m 0028 b9
m 0029 ce
m 002a 00
m 002b 77
m 002c c3
m 002d f0
m 002e 00
m 002f 77
# jump targets, skipped stores sit at 002f 00f5 and 010d
m 00f0 3e
m 00f1 a1
m 00f2 77
m 00f3 18
m 00f4 0c
m 00f5 77
m 00f6 3e
m 00f7 c4
m 00f8 77
m 00f9 c3
m 00fa 06
m 00fb 01
m 0101 3e
m 0102 b2
m 0103 77
m 0104 18
m 0105 f0
m 0106 26
m 0107 90
m 0108 7e
m 0109 26
m 010a 80
m 010b 77
m 010c 76
m 010d 77
m 9010 6b
w ld_imm 8010 5a
w ld_reg 8010 c3
w add_reg 8010 86
w adc_imm 8010 d4
w sub_imm 8010 f4
w sbc_reg 8010 30
w sub_reg 8010 6d
w sbc_imm 8010 67
w and_imm 8010 07
w or_reg 8010 c7
w xor_imm 8010 38
w cp_carry 8010 39
w cp_no_carry 8010 39
w jp_target 8010 a1
w jr_forward 8010 b2
w jr_backward 8010 c4
w mem_read 8010 6b

//--- list.f
common/core_pkg.sv
common/isa_pkg.sv
datapath/alu.sv
datapath/regfile.sv
datapath/datapath.sv
control/control.sv
control/cycle_sequencer.sv
rtl/cpu.sv
bench/cpu_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing
TOP       := cpu_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := NO ERRORS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
